/* source/objdraw_cfg.svh */
//////////////////////////////////////////////////////////////////////
// sizes and raster timing for the object line renderer
// hdump is a continuous count 0..OBJ_HTOTAL-1, 512 max (9-bit)
// OBJ_PW must be above 4, the low nibble always comes from ROM
//////////////////////////////////////////////////////////////////////
`ifndef OBJDRAW_CFG_SVH
`define OBJDRAW_CFG_SVH

// object and pixel sizes
`define OBJ_CW        12    // code width
`define OBJ_PW        8     // pixel width, palette on top of ROM nibble

// horizontal raster
`define OBJ_HTOTAL    384   // pixels per line
`define OBJ_HS_START  320   // hs high from here
`define OBJ_HS_END    352   // hs low again from here
`define OBJ_CEN_DIV   2     // clocks per pixel enable

// set to 1 when the ROM stores the right half of a row first
`define OBJ_SWAPH     0

`endif

/* source/objdraw_pkg.sv */
//////////////////////////////////////////////////////////////////////
// shared types for the object renderer, sized from objdraw_cfg.svh
//////////////////////////////////////////////////////////////////////
`include "objdraw_cfg.svh"

package objdraw_pkg;

    // sprite code as given by the host
    typedef logic [`OBJ_CW-1:0] obj_code_t;

    // line buffer entry and video output pixel
    typedef logic [`OBJ_PW-1:0] pxl_t;

    typedef logic [`OBJ_PW-5:0] pal_t;    // palette, upper pixel bits

    // horizontal position, also the buffer address
    typedef logic [8:0] hpos_t;

    typedef logic [3:0] nib_t;            // ROM pixel, 0 = transparent

    // {code, row[3:0], half}
    typedef logic [`OBJ_CW+4:0] rom_addr_t;

    // sequencer states
    typedef enum logic [1:0] {
        IDLE,   // waiting for draw
        FETCH,  // rom_cs high, waiting for rom_ok
        WRITE   // unpacker busy with the current word
    } draw_state_t;

endpackage

/* source/line_timer.sv */
//////////////////////////////////////////////////////////////////////
// horizontal raster timer, continuous hdump count only
// hs is registered, so it trails the hdump decode by one clock
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "objdraw_cfg.svh"

module line_timer (
    input  logic               clk,
    input  logic               arst_n,
    output logic               pxl_cen,
    output objdraw_pkg::hpos_t hdump,
    output logic               hs
);

    // divider width, at least one bit even for a divide by 1
    localparam int CEN_W = (`OBJ_CEN_DIV > 1) ? $clog2(`OBJ_CEN_DIV) : 1;

    logic [CEN_W-1:0] cen_cnt;
    logic             hs_zone;

    // clock enable divider, one pulse per OBJ_CEN_DIV clocks
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            cen_cnt <= '0;
            pxl_cen <= 1'b0;
        end else if (cen_cnt == CEN_W'(`OBJ_CEN_DIV - 1)) begin
            cen_cnt <= '0;
            pxl_cen <= 1'b1;
        end else begin
            cen_cnt <= cen_cnt + 1'b1;
            pxl_cen <= 1'b0;
        end
    end

    // horizontal count, steps on each pixel enable
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hdump <= '0;
        end else if (pxl_cen) begin
            if (hdump == objdraw_pkg::hpos_t'(`OBJ_HTOTAL - 1))
                hdump <= '0;                // end of line
            else
                hdump <= hdump + 1'b1;
        end
    end

    assign hs_zone = (hdump >= objdraw_pkg::hpos_t'(`OBJ_HS_START)) &&
                     (hdump <  objdraw_pkg::hpos_t'(`OBJ_HS_END));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) hs <= 1'b0;
        else         hs <= hs_zone;         // registered, no decode glitches
    end

endmodule

/* source/draw_fsm.sv */
//////////////////////////////////////////////////////////////////////
// draw command sequencer, two ROM fetches per 16-pixel sprite row
// command fields are captured on accept and may change afterwards
// rom_cs and rom_addr hold steady until rom_ok
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "objdraw_cfg.svh"

module draw_fsm (
    input  logic                   clk,
    input  logic                   arst_n,
    // host command
    input  logic                   draw,
    input  objdraw_pkg::obj_code_t code,
    input  objdraw_pkg::hpos_t     xpos,
    input  logic [3:0]             ysub,
    input  logic                   hflip,
    input  logic                   vflip,
    input  objdraw_pkg::pal_t      pal,
    // graphics ROM
    input  logic                   rom_ok,
    input  logic [31:0]            rom_data,
    input  logic                   unpack_busy,
    output logic                   busy,
    output logic                   rom_cs,
    output objdraw_pkg::rom_addr_t rom_addr,
    // to the unpacker
    output logic                   word_load,
    output logic [31:0]            word_data,
    output objdraw_pkg::hpos_t     base_x,
    output logic                   flip_h,
    output objdraw_pkg::pal_t      pal_q
);

    localparam bit SWAPH = (`OBJ_SWAPH != 0);

    objdraw_pkg::draw_state_t state;
    logic                     second;   // fetching the right-hand word
    logic                     accept;

    // captured command
    objdraw_pkg::obj_code_t code_q;
    objdraw_pkg::hpos_t     xpos_q;
    logic [3:0]             ysub_q;
    logic                   hflip_q;
    logic                   vflip_q;
    logic [3:0]             row;
    logic                   half;

    assign accept = draw && (state == objdraw_pkg::IDLE);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= objdraw_pkg::IDLE;
            second <= 1'b0;
        end else begin
            case (state)
                objdraw_pkg::IDLE: if (draw) begin
                    state  <= objdraw_pkg::FETCH;
                    second <= 1'b0;
                end
                objdraw_pkg::FETCH: if (rom_ok) state <= objdraw_pkg::WRITE;
                objdraw_pkg::WRITE: if (!unpack_busy) begin
                    // unpacker is on its last pixel here
                    if (second) begin
                        state <= objdraw_pkg::IDLE;
                    end else begin
                        state  <= objdraw_pkg::FETCH;
                        second <= 1'b1;
                    end
                end
                default: state <= objdraw_pkg::IDLE;
            endcase
        end
    end

    // command capture, only on accept
    always_ff @(posedge clk) begin
        if (accept) begin
            code_q  <= code;
            xpos_q  <= xpos;
            ysub_q  <= ysub;
            hflip_q <= hflip;
            vflip_q <= vflip;
            pal_q   <= pal;
        end
    end

    assign row  = vflip_q ? ~ysub_q : ysub_q;       // vertical flip picks mirrored row
    assign half = second ^ hflip_q ^ SWAPH;         // hflip draws right half first

    assign busy      = (state != objdraw_pkg::IDLE);
    assign rom_cs    = (state == objdraw_pkg::FETCH);
    assign rom_addr  = {code_q, row, half};
    assign word_load = rom_cs && rom_ok;            // data valid with rom_ok
    assign word_data = rom_data;
    assign base_x    = second ? xpos_q + 9'd8 : xpos_q;  // wraps at 512
    assign flip_h    = hflip_q;

endmodule

/* source/pixel_unpack.sv */
//////////////////////////////////////////////////////////////////////
// unpacks one ROM word into eight buffer writes, one per clock
// word_load is ignored while a word is still being written
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module pixel_unpack (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               word_load,
    input  logic [31:0]        word_data,
    input  objdraw_pkg::hpos_t base_x,
    input  logic               flip_h,
    input  objdraw_pkg::pal_t  pal,
    output logic               unpack_busy,
    output logic               buf_we,
    output objdraw_pkg::hpos_t buf_addr,
    output objdraw_pkg::pxl_t  buf_din
);

    logic                 active;
    logic [2:0]           cnt;      // output pixel index
    logic [2:0]           sel;      // nibble index inside the word
    logic [31:0]          word_q;
    objdraw_pkg::hpos_t   base_q;
    logic                 flip_q;
    objdraw_pkg::pal_t    pal_q;
    objdraw_pkg::nib_t    nib;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active <= 1'b0;
            cnt    <= '0;
        end else if (active) begin
            cnt <= cnt + 1'b1;
            if (cnt == 3'd7) active <= 1'b0;    // eighth write done
        end else if (word_load) begin
            active <= 1'b1;
            cnt    <= '0;
        end
    end

    // word and drawing attributes
    always_ff @(posedge clk) begin
        if (word_load && !active) begin
            word_q <= word_data;
            base_q <= base_x;
            flip_q <= flip_h;
            pal_q  <= pal;
        end
    end

    assign sel = flip_q ? ~cnt : cnt;              // flip reads from the top nibble
    assign nib = word_q[{sel, 2'b00} +: 4];

    // low on the last pixel so the sequencer moves on right after it
    assign unpack_busy = active && (cnt != 3'd7);
    assign buf_we      = active && (nib != 4'd0);  // 0 is transparent
    assign buf_addr    = base_q + {6'd0, cnt};     // 9-bit, wraps at 512
    assign buf_din     = {pal_q, nib};

endmodule

/* source/obj_line_buffer.sv */
//////////////////////////////////////////////////////////////////////
// double line buffer, 512 entries per bank
// banks hold no reset value, the read side clears each entry it shows
// so the contents are only valid from the third line after reset
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module obj_line_buffer (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               hs,
    input  logic               pxl_cen,
    input  logic               flip,
    input  objdraw_pkg::hpos_t hdump,
    input  logic               we,
    input  objdraw_pkg::hpos_t wr_addr,
    input  objdraw_pkg::pxl_t  wr_data,
    output objdraw_pkg::pxl_t  pxl
);

    objdraw_pkg::pxl_t  bank0 [512];
    objdraw_pkg::pxl_t  bank1 [512];

    logic               hs_l;
    logic               rd_bank;    // bank being read and cleared
    objdraw_pkg::hpos_t rd_addr;

    // one port per bank, either the object write or the clear after read
    logic               en0, en1;
    objdraw_pkg::hpos_t addr0, addr1;
    objdraw_pkg::pxl_t  din0, din1;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hs_l    <= 1'b0;
            rd_bank <= 1'b0;
        end else begin
            hs_l <= hs;
            if (hs && !hs_l) rd_bank <= ~rd_bank;   // swap on hs rising edge
        end
    end

    assign rd_addr = hdump ^ {1'b0, {8{flip}}};    // screen flip mirrors the low 8 bits

    assign en0   = rd_bank ? we      : pxl_cen;
    assign addr0 = rd_bank ? wr_addr : rd_addr;
    assign din0  = rd_bank ? wr_data : '0;
    assign en1   = rd_bank ? pxl_cen : we;
    assign addr1 = rd_bank ? rd_addr : wr_addr;
    assign din1  = rd_bank ? '0      : wr_data;

    always_ff @(posedge clk) begin
        if (en0) bank0[addr0] <= din0;
        if (en1) bank1[addr1] <= din1;
    end

    // old value comes out while the entry is cleared
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            pxl <= '0;
        else if (pxl_cen)
            pxl <= rd_bank ? bank1[rd_addr] : bank0[rd_addr];
    end

endmodule

/* source/objdraw_top.sv */
//////////////////////////////////////////////////////////////////////
// object line renderer top, 16-pixel objects into a double buffer
// objects drawn now show up in the line after the next hs rise
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps

module objdraw_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   flip,      // screen flip
    input  logic                   draw,
    input  objdraw_pkg::obj_code_t code,
    input  objdraw_pkg::hpos_t     xpos,
    input  logic [3:0]             ysub,
    input  logic                   hflip,
    input  logic                   vflip,
    input  objdraw_pkg::pal_t      pal,
    input  logic                   rom_ok,
    input  logic [31:0]            rom_data,
    output logic                   busy,
    output logic                   rom_cs,
    output objdraw_pkg::rom_addr_t rom_addr,
    output objdraw_pkg::hpos_t     hdump,
    output logic                   hs,
    output logic                   pxl_cen,
    output objdraw_pkg::pxl_t      pxl
);

    logic               word_load, flip_h, unpack_busy, buf_we;
    logic [31:0]        word_data;
    objdraw_pkg::hpos_t base_x, buf_addr;
    objdraw_pkg::pal_t  pal_q;
    objdraw_pkg::pxl_t  buf_din;

    line_timer u_timer (.clk, .arst_n, .pxl_cen, .hdump, .hs);

    draw_fsm u_fsm (
        .clk, .arst_n, .draw, .code, .xpos, .ysub, .hflip, .vflip, .pal,
        .rom_ok, .rom_data, .unpack_busy, .busy, .rom_cs, .rom_addr,
        .word_load, .word_data, .base_x, .flip_h, .pal_q
    );

    pixel_unpack u_unpack (
        .clk, .arst_n, .word_load, .word_data, .base_x, .flip_h,
        .pal(pal_q), .unpack_busy, .buf_we, .buf_addr, .buf_din
    );

    obj_line_buffer u_linebuf (
        .clk, .arst_n, .hs, .pxl_cen, .flip, .hdump,
        .we(buf_we), .wr_addr(buf_addr), .wr_data(buf_din), .pxl
    );

endmodule

/* sim/objdraw_tb.sv */
//////////////////////////////////////////////////////////////////////
// objdraw_top testbench with a ROM model of random latency 1..4
// sprites only land on buffer positions the current flip reads out
// comparison starts at the sixth line once both banks are cleared
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`include "objdraw_cfg.svh"

module objdraw_tb;

    typedef struct packed {
        objdraw_pkg::obj_code_t code;
        objdraw_pkg::hpos_t     xpos;
        logic [3:0]             ysub;
        logic                   hflip;
        logic                   vflip;
        objdraw_pkg::pal_t      pal;
    } cmd_t;

    localparam int LIMIT = 2000;            // clocks per wait (a line is 768)

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic                   flip = 1'b1;    // warm-up starts flipped
    logic                   draw = 1'b0;
    objdraw_pkg::obj_code_t code;
    objdraw_pkg::hpos_t     xpos;
    logic [3:0]             ysub;
    logic                   hflip, vflip;
    objdraw_pkg::pal_t      pal;
    logic                   rom_ok = 1'b0;
    logic [31:0]            rom_data;
    logic                   busy, rom_cs, hs, pxl_cen;
    objdraw_pkg::rom_addr_t rom_addr;
    objdraw_pkg::hpos_t     hdump;
    objdraw_pkg::pxl_t      pxl;

    logic [31:0]        cmd_rng = 32'h4df2_0bf5;
    logic [31:0]        rom_rng = 32'h4df2_0bf5;
    cmd_t               cmds [8];
    cmd_t               cur;                // command now in the DUT
    int                 sent = 0, fetches = 0, lat_sum = 0;
    int                 errors = 0, checks = 0, period = 0;
    objdraw_pkg::pxl_t  exp_wr [512];       // line being drawn in screen order
    objdraw_pkg::pxl_t  exp_rd [512];       // line on screen now
    objdraw_pkg::pxl_t  chk_exp;
    objdraw_pkg::hpos_t chk_h;
    logic               chk_on = 1'b0, hs_l = 1'b0;

    objdraw_pkg::hpos_t ref_h;              // hdump the raster should show
    logic               ref_hs;
    logic               rst_done = 1'b0;    // reset was released before the last edge
    logic               cen_seen = 1'b0;
    int                 cen_gap = 0;        // clocks since the last pxl_cen

    objdraw_top dut (.clk, .arst_n, .flip, .draw, .code, .xpos, .ysub, .hflip, .vflip, .pal,
                     .rom_ok, .rom_data, .busy, .rom_cs, .rom_addr, .hdump, .hs, .pxl_cen, .pxl);

    initial begin
        forever #4 clk = ~clk;              // 8 ns
    end

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    // ROM contents hashed from the full address with about a quarter transparent
    function automatic logic [31:0] rom_word(input objdraw_pkg::rom_addr_t a);
        logic [31:0] x;
        x = {15'd0, a} * 32'h9e37_79b1;
        x = (x ^ (x >> 15)) * 32'h85eb_ca6b;
        x = x ^ (x >> 13);
        for (int i = 0; i < 8; i++)
            if (x[4*i +: 4] < 4'd4) x[4*i +: 4] = 4'd0;
        return x;
    endfunction

    // code, row (mirrored by vflip), half (left half second when hflip)
    function automatic objdraw_pkg::rom_addr_t exp_addr(input cmd_t c, input logic second);
        return {c.code, c.vflip ? ~c.ysub : c.ysub, second ^ c.hflip ^ (`OBJ_SWAPH != 0)};
    endfunction

    // reference line drawn command by command and then mapped to screen order
    function automatic void ref_line(input int n, input logic f);
        objdraw_pkg::pxl_t  buf_img [512];
        logic [31:0]        w;
        objdraw_pkg::nib_t  nib;
        objdraw_pkg::hpos_t a;
        for (int k = 0; k < 512; k++) buf_img[k] = '0;
        for (int c = 0; c < n; c++)
            for (int h = 0; h < 2; h++) begin
                w = rom_word(exp_addr(cmds[c], h[0]));
                for (int i = 0; i < 8; i++) begin
                    nib = w[4*(cmds[c].hflip ? 7 - i : i) +: 4];
                    a   = cmds[c].xpos + 9'(8*h + i);        // wraps at 512
                    if (nib != 4'd0) buf_img[a] = {cmds[c].pal, nib};
                end
            end
        for (int k = 0; k < 512; k++) exp_wr[k] = buf_img[k ^ (f ? 255 : 0)];
    endfunction

    function automatic cmd_t rand_cmd(input int xspan);
        cmd_t c;
        cmd_rng = xorshift(cmd_rng);
        c = cmd_rng[$bits(cmd_t)-1:0];
        cmd_rng = xorshift(cmd_rng);
        c.xpos = 9'(cmd_rng % xspan);       // keep clear of unread positions
        return c;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        errors++;
        $display("Mismatch at %0t ns: %s got %0h expected %0h", $time, name, got, expected);
    endtask

    task automatic finish_run();
        $display("errors %0d, pixel checks %0d, commands %0d", errors, checks, sent);
        if (errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    endtask

    task automatic timeout(input string what);
        errors++;
        $display("timeout at %0t ns waiting for %s", $time, what);
        finish_run();
    endtask

    task automatic tick();                  // next edge plus drive delay
        @(posedge clk);
        #1;
    endtask

    task automatic wait_hs(input logic level);
        int n;
        n = 0;
        while (hs !== level && n < LIMIT) begin
            tick();
            n++;
        end
        if (hs !== level) timeout(level ? "hs high" : "hs low");
    endtask

    // flip changes right after the bank swap so that a whole line sees one value
    task automatic next_period(input logic f);
        wait_hs(1'b0);
        wait_hs(1'b1);
        tick();
        flip = f;
    endtask

    task automatic send_cmd(input cmd_t c);
        int n;
        n = 0;
        cur = c;
        lat_sum = 0;
        sent++;
        {code, xpos, ysub, hflip, vflip, pal} = c;
        draw = 1'b1;
        tick();                             // accepted here since busy was low
        draw = 1'b0;
        {code, xpos, ysub, hflip, vflip, pal} = ~c;     // fields no longer used
        while (busy === 1'b1 && n < LIMIT) begin
            tick();
            n++;
        end
        if (busy !== 1'b0) timeout("busy low");
        assert (n == 18 + lat_sum) else report_mismatch("busy cycles", n, 18 + lat_sum);
    endtask

    // commands go in after hs falls and show on the line after the next hs
    task automatic draw_line(input int n, input logic f);
        wait_hs(1'b0);
        for (int i = 0; i < n; i++) send_cmd(cmds[i]);
        ref_line(n, f);
        next_period(f);
    endtask

    // ROM model answering each rom_cs after a random number of clocks
    initial begin : rom_model
        int lat;
        forever begin
            tick();
            if (rom_cs === 1'b1 && !rom_ok) begin
                assert (fetches < 2 * sent) else begin
                    errors++;
                    $display("rom_cs went high at %0t ns with no draw command", $time);
                end
                assert (rom_addr === exp_addr(cur, fetches[0]))
                    else report_mismatch("rom_addr", rom_addr, exp_addr(cur, fetches[0]));
                lat = 1 + int'(rom_rng % 4);
                rom_rng = xorshift(rom_rng);
                lat_sum += lat;
                repeat (lat) tick();
                assert (rom_cs === 1'b1) else begin
                    errors++;
                    $display("rom_cs dropped at %0t ns before rom_ok", $time);
                end
                rom_data = rom_word(rom_addr);
                rom_ok = 1'b1;
                tick();                     // taken on this edge
                rom_ok = 1'b0;
                fetches++;
            end
        end
    end

    // pixel compare sampled on the falling edge
    always @(negedge clk) begin
        if (chk_on) begin
            checks++;
            assert (pxl === chk_exp)
                else report_mismatch($sformatf("pxl (hdump %0d)", chk_h), pxl, chk_exp);
        end
        chk_on  = (pxl_cen === 1'b1) && (period >= 5);
        chk_exp = exp_rd[hdump];            // read on the next rising edge
        chk_h   = hdump;
        if (hs === 1'b1 && !hs_l) begin     // bank swap makes the next read the new line
            period++;
            for (int k = 0; k < 512; k++) exp_rd[k] = exp_wr[k];
        end
        hs_l = (hs === 1'b1);
    end

    // raster timing counted from the first edge after reset release
    always @(negedge clk) begin
        if (!rst_done) begin
            ref_h    = '0;
            ref_hs   = 1'b0;
            cen_gap  = 0;
            cen_seen = 1'b0;
        end else begin
            assert (hdump === ref_h) else report_mismatch("hdump", hdump, ref_h);
            assert (hs === ref_hs) else report_mismatch("hs", hs, ref_hs);
            cen_gap++;
            if (pxl_cen === 1'b1) begin
                assert (cen_gap == `OBJ_CEN_DIV || !cen_seen)
                    else report_mismatch("pxl_cen period", cen_gap, `OBJ_CEN_DIV);
                cen_gap  = 0;
                cen_seen = 1'b1;
            end else begin
                assert (cen_gap < `OBJ_CEN_DIV) else begin
                    errors++;
                    $display("pxl_cen missing for %0d clocks at %0t ns", cen_gap, $time);
                end
            end
            // hs follows the count one clock later
            ref_hs = (ref_h >= `OBJ_HS_START) && (ref_h < `OBJ_HS_END);
            if (pxl_cen === 1'b1) begin
                if (ref_h == `OBJ_HTOTAL - 1)
                    ref_h = '0;
                else
                    ref_h = ref_h + 1'b1;
            end
        end
        rst_done = (arst_n === 1'b1);
    end

    initial begin : stimulus
        for (int k = 0; k < 512; k++) exp_wr[k] = '0;
        {code, xpos, ysub, hflip, vflip, pal} = '0;
        rom_data = '0;
        arst_n = 1'b0;
        repeat (16) tick();
        arst_n = 1'b1;
        assert (busy === 1'b0 && rom_cs === 1'b0) else begin
            errors++;
            $display("busy or rom_cs high right after reset");
        end
        // warm-up clears both banks under both flip settings
        next_period(1'b1);
        next_period(1'b1);
        next_period(1'b0);
        next_period(1'b0);
        next_period(1'b0);
        cmds[0] = {12'h123, 9'd100, 4'd5, 1'b0, 1'b0, 4'ha};   // single plain sprite
        draw_line(1, 1'b0);
        draw_line(0, 1'b0);                 // empty after a populated line
        cmds[0] = {12'h2a7, 9'd20, 4'd3, 1'b1, 1'b0, 4'h3};
        cmds[1] = {12'h2a7, 9'd60, 4'd3, 1'b0, 1'b1, 4'h5};
        cmds[2] = {12'h2a7, 9'd140, 4'd3, 1'b1, 1'b1, 4'h7};
        cmds[3] = {12'h2a7, 9'd180, 4'd3, 1'b0, 1'b0, 4'h9};
        draw_line(4, 1'b0);
        for (int l = 0; l < 3; l++) begin   // overlapping random sprites
            for (int i = 0; i < 6; i++) cmds[i] = rand_cmd(228);
            draw_line(6, 1'b0);
        end
        draw_line(0, 1'b0);
        cmds[0] = {12'h055, 9'd504, 4'd7, 1'b0, 1'b0, 4'hc};   // wraps to 0..7
        cmds[1] = {12'h3c1, 9'd500, 4'd2, 1'b1, 1'b0, 4'h6};
        cmds[2] = {12'h0f0, 9'd508, 4'd9, 1'b0, 1'b1, 4'h2};
        cmds[3] = rand_cmd(228);
        cmds[4] = rand_cmd(228);
        draw_line(5, 1'b1);                 // screen flip
        for (int i = 0; i < 6; i++) cmds[i] = rand_cmd(228);
        draw_line(6, 1'b1);
        draw_line(0, 1'b1);
        draw_line(0, 1'b1);
        repeat (4) tick();
        assert (fetches == 2 * sent) else report_mismatch("ROM fetch count", fetches, 2 * sent);
        finish_run();
    end

endmodule

/* tb.f */
+incdir+source
source/objdraw_pkg.sv
source/line_timer.sv
source/draw_fsm.sv
source/pixel_unpack.sv
source/obj_line_buffer.sv
source/objdraw_top.sv
sim/objdraw_tb.sv

/* Bender.yml */
package:
  name: objdraw

sources:
  - include_dirs:
      - source
    files:
      - source/objdraw_pkg.sv
      - source/line_timer.sv
      - source/draw_fsm.sv
      - source/pixel_unpack.sv
      - source/obj_line_buffer.sv
      - source/objdraw_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - sim/objdraw_tb.sv
